// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f project.f --top-module tb_id_stage -o tb_id_stage
	./obj_dir/tb_id_stage | tee /dev/stderr | grep -q '\*\*\* TEST PASSED \*\*\*'

clean:
	rm -rf obj_dir

// ==== project.f ====
+incdir+include
verilog/id_pkg.sv
verilog/id_bus_if.sv
verilog/id_stage_reg.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/operand_bypass.sv
verilog/branch_unit.sv
verilog/id_stage.sv
tests/tb_id_stage.sv

// ==== include/id_test_table.svh ====
// one row per instruction held in the stage
typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic        allow;
    logic        es_we;
    logic        es_ld;
    logic [4:0]  es_a;
    logic [31:0] es_d;
    logic        ms_we;
    logic [4:0]  ms_a;
    logic [31:0] ms_d;
    logic        ws_we;
    logic [4:0]  ws_a;
    logic [31:0] ws_d;
    logic [11:0] alu;
    logic [1:0]  s1sel;
    logic        s2imm;
    logic [31:0] imm;
    logic        rf_we;
    logic [4:0]  waddr;
    logic [1:0]  mem;
    logic        taken;
    logic [31:0] target;
} row_t;

// src1 selection: 0 rj value, 1 pc, 2 not checked
// mem: 0 none, 1 load, 2 store

function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk);
    return {op, rk, rj, rd};
endfunction

function automatic logic [31:0] enc_ri12(input logic [9:0] op, input logic [4:0] rd,
                                         input logic [4:0] rj, input logic [11:0] i12);
    return {op, i12, rj, rd};
endfunction

function automatic logic [31:0] enc_ri20(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [19:0] i20);
    return {op, i20, rd};
endfunction

function automatic logic [31:0] enc_ri16(input logic [5:0] op, input logic [4:0] rd,
                                         input logic [4:0] rj, input logic [15:0] i16);
    return {op, i16, rj, rd};
endfunction

// the upper ten offset bits sit in the low bits of the word
function automatic logic [31:0] enc_i26(input logic [5:0] op, input logic [25:0] offs);
    return {op, offs[15:0], offs[25:16]};
endfunction

task automatic load_table();
    add_row(enc_3r(17'h00020, 3, 1, 2), 32'h1c000000, 1, 12'h001, 0, 0, 0, 1, 3, 0, 0, 0);
    add_row(enc_3r(17'h00022, 4, 5, 6), 32'h1c000004, 1, 12'h002, 0, 0, 0, 1, 4, 0, 0, 0);
    add_row(enc_3r(17'h00028, 1, 2, 3), 32'h1c000008, 1, 12'h020, 0, 0, 0, 1, 1, 0, 0, 0);
    add_row(enc_ri12(10'h00a, 7, 8, 12'hffd), 32'h1c00000c, 1, 12'h001, 0, 1,
            32'hfffffffd, 1, 7, 0, 0, 0);
    add_row(enc_ri12(10'h008, 9, 10, 12'h800), 32'h1c000010, 1, 12'h004, 0, 1,
            32'hfffff800, 1, 9, 0, 0, 0);
    add_row(enc_ri12(10'h00d, 11, 12, 12'hf0f), 32'h1c000014, 1, 12'h010, 0, 1,
            32'h00000f0f, 1, 11, 0, 0, 0);
    add_row(enc_ri12(10'h00e, 13, 14, 12'h800), 32'h1c000018, 1, 12'h040, 0, 1,
            32'h00000800, 1, 13, 0, 0, 0);
    add_row(enc_ri12(10'h00f, 15, 16, 12'habc), 32'h1c00001c, 1, 12'h080, 0, 1,
            32'h00000abc, 1, 15, 0, 0, 0);
    add_row(enc_3r(17'h00081, 17, 18, 5), 32'h1c000020, 1, 12'h100, 0, 1, 5, 1, 17, 0, 0, 0);
    add_row(enc_3r(17'h00091, 5, 6, 31), 32'h1c000024, 1, 12'h400, 0, 1, 31, 1, 5, 0, 0, 0);
    add_row(enc_ri20(7'h0a, 19, 20'hfedcb), 32'h1c000028, 1, 12'h800, 2, 1,
            32'hfedcb000, 1, 19, 0, 0, 0);
    add_row(enc_ri20(7'h0e, 20, 20'h00001), 32'h1c000100, 1, 12'h001, 1, 1,
            32'h00001000, 1, 20, 0, 0, 0);
    add_row(enc_ri12(10'h0a2, 21, 22, 12'h008), 32'h1c000104, 1, 12'h001, 0, 1, 8, 1, 21, 1,
            0, 0);
    add_row(enc_ri12(10'h0a6, 23, 24, 12'hffc), 32'h1c000108, 1, 12'h001, 0, 1,
            32'hfffffffc, 0, 0, 2, 0, 0);
    // execute wins over memory on rj
    set_fwd(1, 0, 26, 32'h11111111, 1, 26, 32'h22222222, 1, 27, 32'h33333333);
    add_row(enc_3r(17'h00020, 25, 26, 27), 32'h1c00010c, 1, 12'h001, 0, 0, 0, 1, 25, 0, 0, 0);
    // memory wins over writeback on rj while rk is r0
    set_fwd(1, 0, 0, 32'hdeadbeef, 1, 29, 32'hcafef00d, 1, 29, 32'h55aa55aa);
    add_row(enc_3r(17'h0002a, 28, 29, 0), 32'h1c000110, 1, 12'h040, 0, 0, 0, 1, 28, 0, 0, 0);
    // load in execute matches only the rk bits of the immediate
    set_fwd(1, 1, 31, 32'h77777777, 0, 0, 0, 0, 0, 0);
    add_row(enc_ri12(10'h00a, 2, 3, 12'h01f), 32'h1c000114, 1, 12'h001, 0, 1, 32'h1f, 1, 2,
            0, 0, 0);
    set_fwd(1, 0, 4, 32'h10, 1, 5, 32'h10, 0, 0, 0);
    add_row(enc_ri16(6'h16, 5, 4, 16'h0010), 32'h1c000200, 1, 0, 0, 0, 0, 0, 0, 0, 1,
            32'h1c000240);
    set_fwd(1, 0, 4, 32'h10, 1, 5, 32'h10, 0, 0, 0);
    add_row(enc_ri16(6'h17, 5, 4, 16'h0010), 32'h1c000204, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    set_fwd(1, 0, 4, 32'hffffffff, 1, 5, 32'h1, 0, 0, 0);
    add_row(enc_ri16(6'h18, 5, 4, 16'hfffe), 32'h1c000300, 1, 0, 0, 0, 0, 0, 0, 0, 1,
            32'h1c0002f8);
    set_fwd(1, 0, 4, 32'hffffffff, 1, 5, 32'h1, 0, 0, 0);
    add_row(enc_ri16(6'h19, 5, 4, 16'hfffe), 32'h1c000304, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    set_fwd(1, 0, 4, 32'hffffffff, 1, 5, 32'h1, 0, 0, 0);
    add_row(enc_ri16(6'h1a, 5, 4, 16'hfffe), 32'h1c000308, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    set_fwd(1, 0, 4, 32'hffffffff, 1, 5, 32'h1, 0, 0, 0);
    add_row(enc_ri16(6'h1b, 5, 4, 16'h0004), 32'h1c00030c, 1, 0, 0, 0, 0, 0, 0, 0, 1,
            32'h1c00031c);
    // execute refuses, so only the squash can empty the stage
    add_row(enc_i26(6'h14, 26'h0000100), 32'h1c000400, 0, 0, 2, 0, 0, 0, 0, 0, 1,
            32'h1c000800);
    add_row(enc_i26(6'h15, 26'h3ffffff), 32'h1c000500, 1, 12'h001, 1, 1, 4, 1, 1, 0, 1,
            32'h1c0004fc);
    set_fwd(1, 0, 6, 32'h1c001000, 0, 0, 0, 0, 0, 0);
    add_row(enc_ri16(6'h13, 1, 6, 16'h0008), 32'h1c000600, 1, 12'h001, 1, 1, 4, 1, 1, 0, 1,
            32'h1c001020);
    add_row(enc_3r(17'h0002b, 8, 9, 10), 32'h1c000700, 0, 12'h080, 0, 0, 0, 1, 8, 0, 0, 0);
endtask

// ==== tests/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;

    logic        clk = 1'b0;
    logic        resetn, fs_to_ds_valid, es_allowin, except_flush;
    logic [31:0] fs_inst, fs_pc, es_wdata, ms_wdata, ws_wdata;
    logic        es_we, es_res_from_mem, ms_we, ws_we;
    logic [4:0]  es_waddr, ms_waddr, ws_waddr;
    logic        ds_allowin, ds_to_es_valid, br_taken;
    logic [31:0] br_target, ds_alu_src1, ds_alu_src2, ds_store_data, ds_pc_out;
    logic [11:0] ds_alu_op;
    logic        ds_res_from_mem, ds_mem_we, ds_rf_we;
    logic [4:0]  ds_rf_waddr;

    `include "id_test_table.svh"

    row_t        cur;
    row_t        table_q[$];
    logic [31:0] model [32];
    integer      seed = 10;
    integer      errors = 0;
    integer      passed = 0;
    integer      failed = 0;

    id_stage i_dut (.*);

    always #20 clk = !clk;

    function automatic void set_fwd(input logic ew, input logic ld, input logic [4:0] ea,
                                    input logic [31:0] ed, input logic mw,
                                    input logic [4:0] ma, input logic [31:0] md,
                                    input logic ww, input logic [4:0] wa,
                                    input logic [31:0] wd);
        cur.es_we = ew;
        cur.es_ld = ld;
        cur.es_a  = ea;
        cur.es_d  = ed;
        cur.ms_we = mw;
        cur.ms_a  = ma;
        cur.ms_d  = md;
        cur.ws_we = ww;
        cur.ws_a  = wa;
        cur.ws_d  = wd;
    endfunction

    function automatic void add_row(input logic [31:0] inst, input logic [31:0] pc,
                                    input logic allow, input logic [11:0] alu,
                                    input logic [1:0] s1sel, input logic s2imm,
                                    input logic [31:0] imm, input logic rf_we,
                                    input logic [4:0] waddr, input logic [1:0] mem,
                                    input logic taken, input logic [31:0] target);
        cur.inst   = inst;
        cur.pc     = pc;
        cur.allow  = allow;
        cur.alu    = alu;
        cur.s1sel  = s1sel;
        cur.s2imm  = s2imm;
        cur.imm    = imm;
        cur.rf_we  = rf_we;
        cur.waddr  = waddr;
        cur.mem    = mem;
        cur.taken  = taken;
        cur.target = target;
        table_q.push_back(cur);
        cur = '0;
    endfunction

    // youngest matching stage wins, r0 stays zero
    function automatic logic [31:0] operand(input row_t r, input logic [4:0] a);
        if (a == 5'd0) return 32'd0;
        if (r.es_we && r.es_a == a) return r.es_d;
        if (r.ms_we && r.ms_a == a) return r.ms_d;
        if (r.ws_we && r.ws_a == a) return r.ws_d;
        return model[a];
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic drive_fwd(input row_t r);
        es_we           = r.es_we;
        es_res_from_mem = r.es_ld;
        es_waddr        = r.es_a;
        es_wdata        = r.es_d;
        ms_we           = r.ms_we;
        ms_waddr        = r.ms_a;
        ms_wdata        = r.ms_d;
        ws_we           = r.ws_we;
        ws_waddr        = r.ws_a;
        ws_wdata        = r.ws_d;
    endtask

    task automatic report(input string name, input integer err0);
        if (errors == err0) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: failed", name);
            failed++;
        end
    endtask

    // offer one instruction and let it into the stage
    task automatic offer(input logic [31:0] inst, input logic [31:0] pc);
        integer n;
        fs_to_ds_valid = 1'b1;
        fs_inst        = inst;
        fs_pc          = pc;
        for (n = 0; n < 10; n++) begin
            @(negedge clk);
            if (ds_allowin) break;
        end
        if (n == 10) begin
            $display("timeout: stage never accepted instruction %h", inst);
            errors++;
        end
        @(posedge clk);
        #2;
        fs_to_ds_valid = 1'b0;
    endtask

    task automatic wait_out_valid();
        integer n;
        for (n = 0; n < 10; n++) begin
            @(negedge clk);
            if (ds_to_es_valid) break;
        end
        if (n == 10) begin
            $display("timeout: ds_to_es_valid never rose at %0t ns", $time);
            errors++;
        end
    endtask

    task automatic run_row(input integer idx);
        row_t        r;
        integer      err0;
        logic        use_rd;
        r = table_q[idx];
        err0 = errors;
        use_rd = r.mem == 2 || (r.inst[31:26] >= 6'h16 && r.inst[31:26] <= 6'h1b);
        @(posedge clk);
        #2;
        es_allowin = r.allow;
        drive_fwd(r);
        offer(r.inst, r.pc);
        wait_out_valid();
        check_val("ds_alu_op", {20'd0, r.alu}, {20'd0, ds_alu_op});
        if (r.s1sel == 0) check_val("ds_alu_src1", operand(r, r.inst[9:5]), ds_alu_src1);
        if (r.s1sel == 1) check_val("ds_alu_src1", r.pc, ds_alu_src1);
        check_val("ds_alu_src2", r.s2imm ? r.imm
                  : operand(r, use_rd ? r.inst[4:0] : r.inst[14:10]), ds_alu_src2);
        check_val("ds_rf_we", {31'd0, r.rf_we}, {31'd0, ds_rf_we});
        if (r.rf_we) check_val("ds_rf_waddr", {27'd0, r.waddr}, {27'd0, ds_rf_waddr});
        check_val("ds_res_from_mem", {31'd0, r.mem == 1}, {31'd0, ds_res_from_mem});
        check_val("ds_mem_we", {31'd0, r.mem == 2}, {31'd0, ds_mem_we});
        if (r.mem == 2) check_val("ds_store_data", operand(r, r.inst[4:0]), ds_store_data);
        check_val("br_taken", {31'd0, r.taken}, {31'd0, br_taken});
        if (r.taken) check_val("br_target", r.target, br_target);
        @(negedge clk);
        if (r.taken) begin
            check_val("ds_to_es_valid", 0, {31'd0, ds_to_es_valid});
        end else if (!r.allow) begin
            check_val("ds_to_es_valid", 1, {31'd0, ds_to_es_valid});
            check_val("ds_allowin", 0, {31'd0, ds_allowin});
            if (r.s1sel == 0) begin
                check_val("ds_alu_src1", operand(r, r.inst[9:5]), ds_alu_src1);
            end
            check_val("ds_pc_out", r.pc, ds_pc_out);
        end
        @(posedge clk);
        #2;
        es_allowin = 1'b1;
        drive_fwd('0);
        if (r.ws_we && r.ws_a != 5'd0) model[r.ws_a] = r.ws_d;
        report($sformatf("row %0d inst %h", idx, r.inst), err0);
    endtask

    task automatic load_use();
        integer err0;
        err0 = errors;
        @(posedge clk);
        #2;
        es_we           = 1'b1;
        es_res_from_mem = 1'b1;
        es_waddr        = 5'd2;
        es_wdata        = 32'h0badf00d;
        offer(enc_3r(17'h00020, 3, 1, 2), 32'h1c000800);
        repeat (3) begin
            @(negedge clk);
            check_val("ds_to_es_valid", 0, {31'd0, ds_to_es_valid});
            check_val("ds_allowin", 0, {31'd0, ds_allowin});
        end
        @(posedge clk);
        #2;
        es_res_from_mem = 1'b0;
        @(negedge clk);
        check_val("ds_to_es_valid", 1, {31'd0, ds_to_es_valid});
        check_val("ds_allowin", 1, {31'd0, ds_allowin});
        check_val("ds_alu_src2", 32'h0badf00d, ds_alu_src2);
        @(posedge clk);
        #2;
        es_we = 1'b0;
        report("load-use stall", err0);
    endtask

    task automatic flush();
        integer err0;
        err0 = errors;
        @(posedge clk);
        #2;
        es_allowin = 1'b0;
        offer(enc_3r(17'h00020, 3, 1, 2), 32'h1c000900);
        @(negedge clk);
        check_val("ds_to_es_valid", 1, {31'd0, ds_to_es_valid});
        check_val("ds_allowin", 0, {31'd0, ds_allowin});
        @(posedge clk);
        #2;
        except_flush = 1'b1;
        @(posedge clk);
        #2;
        except_flush = 1'b0;
        @(negedge clk);
        check_val("ds_to_es_valid", 0, {31'd0, ds_to_es_valid});
        check_val("ds_allowin", 1, {31'd0, ds_allowin});
        @(posedge clk);
        #2;
        es_allowin = 1'b1;
        report("flush", err0);
    endtask

    initial begin
        integer err0;
        resetn         = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_inst        = 32'd0;
        fs_pc          = 32'd0;
        es_allowin     = 1'b1;
        except_flush   = 1'b0;
        drive_fwd('0);
        cur = '0;
        model[0] = 32'd0;
        load_table();
        repeat (4) @(posedge clk);
        #2;
        resetn = 1'b1;
        err0 = errors;
        @(negedge clk);
        check_val("ds_to_es_valid", 0, {31'd0, ds_to_es_valid});
        check_val("br_taken", 0, {31'd0, br_taken});
        check_val("ds_mem_we", 0, {31'd0, ds_mem_we});
        check_val("ds_allowin", 1, {31'd0, ds_allowin});
        report("reset", err0);
        // fill r1..r31 through the writeback port
        for (int a = 1; a < 32; a++) begin
            @(posedge clk);
            #2;
            ws_we    = 1'b1;
            ws_waddr = a[4:0];
            ws_wdata = $random(seed);
            model[a] = ws_wdata;
        end
        @(posedge clk);
        #2;
        ws_we = 1'b0;
        for (int i = 0; i < table_q.size(); i++) begin
            run_row(i);
        end
        load_use();
        flush();
        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (errors == 0 && failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  logic          ds_valid,
    input  id_pkg::word_t ds_pc,
    input  id_pkg::word_t rj_value,
    input  id_pkg::word_t rkd_value,
    dec_if.branch         dec,
    output logic          br_taken,
    output id_pkg::word_t br_target
);
    import id_pkg::*;

    logic rj_eq_rd, rj_ge_rd, rj_geu_rd;

    assign rj_eq_rd  = rj_value == rkd_value;
    assign rj_ge_rd  = $signed(rj_value) >= $signed(rkd_value);
    assign rj_geu_rd = rj_value >= rkd_value;

    assign br_taken = ds_valid && (
                          (dec.is_beq  &&  rj_eq_rd)
                       || (dec.is_bne  && !rj_eq_rd)
                       || (dec.is_blt  && !rj_ge_rd)
                       || (dec.is_bge  &&  rj_ge_rd)
                       || (dec.is_bltu && !rj_geu_rd)
                       || (dec.is_bgeu &&  rj_geu_rd)
                       || dec.is_b || dec.is_bl || dec.is_jirl);

    // jirl is register relative, everything else pc relative
    assign br_target = dec.is_jirl ? rj_value + dec.br_offs : ds_pc + dec.br_offs;

endmodule

// ==== verilog/id_bus_if.sv ====
`timescale 1ns/1ps

// decoded control of the instruction held in the stage
interface dec_if;
    import id_pkg::*;

    reg_addr_t raddr1, raddr2;
    logic      need_r1, need_r2;
    logic      src1_is_pc, src2_is_imm;
    word_t     imm;
    alu_op_t   alu_op;
    logic      res_from_mem, mem_we, rf_we;
    reg_addr_t rf_waddr;
    logic      is_b, is_bl, is_jirl;
    logic      is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
    word_t     br_offs;

    modport dec (
        output raddr1, raddr2, need_r1, need_r2, src1_is_pc, src2_is_imm, imm,
               alu_op, res_from_mem, mem_we, rf_we, rf_waddr,
               is_b, is_bl, is_jirl, is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu,
               br_offs
    );
    modport bypass (input raddr1, raddr2, need_r1, need_r2);
    modport branch (
        input is_b, is_bl, is_jirl, is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu,
              br_offs
    );
    modport stage (
        input src1_is_pc, src2_is_imm, imm, alu_op, res_from_mem, mem_we, rf_we, rf_waddr
    );
endinterface

// results on their way back from execute, memory and writeback
interface wb_fwd_if;
    import id_pkg::*;

    logic      es_we, es_res_from_mem;
    reg_addr_t es_waddr;
    word_t     es_wdata;
    logic      ms_we;
    reg_addr_t ms_waddr;
    word_t     ms_wdata;
    logic      ws_we;
    reg_addr_t ws_waddr;
    word_t     ws_wdata;

    modport src (
        output es_we, es_res_from_mem, es_waddr, es_wdata,
               ms_we, ms_waddr, ms_wdata, ws_we, ws_waddr, ws_wdata
    );
    modport bypass (
        input es_we, es_res_from_mem, es_waddr, es_wdata,
              ms_we, ms_waddr, ms_wdata, ws_we, ws_waddr, ws_wdata
    );
    modport rf_write (input ws_we, ws_waddr, ws_wdata);
endinterface

// ==== verilog/id_pkg.sv ====
package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;

    // bit positions in alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // inst[31:26]
    localparam logic [5:0] OP6_SPECIAL   = 6'h00;
    localparam logic [5:0] OP6_LU12I     = 6'h05;
    localparam logic [5:0] OP6_PCADDU12I = 6'h07;
    localparam logic [5:0] OP6_MEM       = 6'h0a;
    localparam logic [5:0] OP6_JIRL      = 6'h13;
    localparam logic [5:0] OP6_B         = 6'h14;
    localparam logic [5:0] OP6_BL        = 6'h15;
    localparam logic [5:0] OP6_BEQ       = 6'h16;
    localparam logic [5:0] OP6_BNE       = 6'h17;
    localparam logic [5:0] OP6_BLT       = 6'h18;
    localparam logic [5:0] OP6_BGE       = 6'h19;
    localparam logic [5:0] OP6_BLTU      = 6'h1a;
    localparam logic [5:0] OP6_BGEU      = 6'h1b;

    // inst[25:22]
    localparam logic [3:0] OP4_3R     = 4'h0;
    localparam logic [3:0] OP4_SHIFTI = 4'h1;
    localparam logic [3:0] OP4_LD_W   = 4'h2;
    localparam logic [3:0] OP4_ST_W   = 4'h6;
    localparam logic [3:0] OP4_SLTI   = 4'h8;
    localparam logic [3:0] OP4_SLTUI  = 4'h9;
    localparam logic [3:0] OP4_ADDI   = 4'ha;
    localparam logic [3:0] OP4_ANDI   = 4'hd;
    localparam logic [3:0] OP4_ORI    = 4'he;
    localparam logic [3:0] OP4_XORI   = 4'hf;

    // inst[21:20]
    localparam logic [1:0] OP2_SHIFTI = 2'h0;
    localparam logic [1:0] OP2_3R     = 2'h1;

    // inst[19:15]
    localparam logic [4:0] OP5_ADD  = 5'h00;
    localparam logic [4:0] OP5_SUB  = 5'h02;
    localparam logic [4:0] OP5_SLT  = 5'h04;
    localparam logic [4:0] OP5_SLTU = 5'h05;
    localparam logic [4:0] OP5_NOR  = 5'h08;
    localparam logic [4:0] OP5_AND  = 5'h09;
    localparam logic [4:0] OP5_OR   = 5'h0a;
    localparam logic [4:0] OP5_XOR  = 5'h0b;
    localparam logic [4:0] OP5_SLLI = 5'h01;
    localparam logic [4:0] OP5_SRLI = 5'h09;
    localparam logic [4:0] OP5_SRAI = 5'h11;

    // link register for bl
    localparam reg_addr_t REG_RA = 5'd1;

    // addi.w r0, r0, 0
    localparam word_t INST_NOP = 32'h0280_0000;

endpackage

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic                clk,
    input  logic                resetn,
    input  logic                fs_to_ds_valid,
    input  id_pkg::word_t       fs_inst,
    input  id_pkg::word_t       fs_pc,
    input  logic                es_allowin,
    input  logic                except_flush,
    input  logic                es_we,
    input  logic                es_res_from_mem,
    input  id_pkg::reg_addr_t   es_waddr,
    input  id_pkg::word_t       es_wdata,
    input  logic                ms_we,
    input  id_pkg::reg_addr_t   ms_waddr,
    input  id_pkg::word_t       ms_wdata,
    input  logic                ws_we,
    input  id_pkg::reg_addr_t   ws_waddr,
    input  id_pkg::word_t       ws_wdata,
    output logic                ds_allowin,
    output logic                ds_to_es_valid,
    output logic                br_taken,
    output id_pkg::word_t       br_target,
    output id_pkg::alu_op_t     ds_alu_op,
    output id_pkg::word_t       ds_alu_src1,
    output id_pkg::word_t       ds_alu_src2,
    output logic                ds_res_from_mem,
    output logic                ds_mem_we,
    output logic                ds_rf_we,
    output id_pkg::reg_addr_t   ds_rf_waddr,
    output id_pkg::word_t       ds_store_data,
    output id_pkg::word_t       ds_pc_out
);
    import id_pkg::*;

    logic  ds_valid, stall;
    word_t ds_inst, ds_pc;
    word_t rdata1, rdata2, rj_value, rkd_value;

    dec_if    dec ();
    wb_fwd_if fwd ();

    assign fwd.es_we           = es_we;
    assign fwd.es_res_from_mem = es_res_from_mem;
    assign fwd.es_waddr        = es_waddr;
    assign fwd.es_wdata        = es_wdata;
    assign fwd.ms_we           = ms_we;
    assign fwd.ms_waddr        = ms_waddr;
    assign fwd.ms_wdata        = ms_wdata;
    assign fwd.ws_we           = ws_we;
    assign fwd.ws_waddr        = ws_waddr;
    assign fwd.ws_wdata        = ws_wdata;

    id_stage_reg u_stage_reg (
        .clk, .resetn, .fs_to_ds_valid, .fs_inst, .fs_pc, .es_allowin, .stall,
        .br_taken, .except_flush, .ds_valid, .ds_allowin, .ds_to_es_valid,
        .ds_inst, .ds_pc
    );

    inst_decoder u_decoder (.ds_inst, .dec(dec.dec));

    regfile u_regfile (
        .clk, .raddr1(dec.raddr1), .raddr2(dec.raddr2), .rdata1, .rdata2,
        .wb(fwd.rf_write)
    );

    operand_bypass u_bypass (
        .rdata1, .rdata2, .ds_valid, .dec(dec.bypass), .fwd(fwd.bypass),
        .rj_value, .rkd_value, .stall
    );

    branch_unit u_branch (
        .ds_valid, .ds_pc, .rj_value, .rkd_value, .dec(dec.branch), .br_taken, .br_target
    );

    assign ds_alu_src1 = dec.src1_is_pc ? ds_pc : rj_value;
    assign ds_alu_src2 = dec.src2_is_imm ? dec.imm : rkd_value;

    assign ds_alu_op       = dec.alu_op;
    assign ds_res_from_mem = dec.res_from_mem;
    assign ds_mem_we       = dec.mem_we && ds_valid;
    assign ds_rf_we        = dec.rf_we;
    assign ds_rf_waddr     = dec.rf_waddr;
    assign ds_store_data   = rkd_value;
    assign ds_pc_out       = ds_pc;

endmodule

// ==== verilog/id_stage_reg.sv ====
`timescale 1ns/1ps

module id_stage_reg (
    input  logic          clk,
    input  logic          resetn,
    input  logic          fs_to_ds_valid,
    input  id_pkg::word_t fs_inst,
    input  id_pkg::word_t fs_pc,
    input  logic          es_allowin,
    input  logic          stall,
    input  logic          br_taken,
    input  logic          except_flush,
    output logic          ds_valid,
    output logic          ds_allowin,
    output logic          ds_to_es_valid,
    output id_pkg::word_t ds_inst,
    output id_pkg::word_t ds_pc
);
    import id_pkg::*;

    assign ds_allowin     = !ds_valid || (!stall && es_allowin);
    assign ds_to_es_valid = ds_valid && !stall;

    // squash wins over a new fetch
    always_ff @(posedge clk) begin
        if (!resetn || br_taken || except_flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_inst <= INST_NOP;
        end else if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    // an offered instruction that execute refuses is still here next cycle
    a_hold_on_backpressure: assert property (
        @(posedge clk) disable iff (!resetn)
        (ds_to_es_valid && !es_allowin && !br_taken && !except_flush)
            |=> (ds_valid && $stable(ds_inst) && $stable(ds_pc))
    ) else $error("stage lost its instruction under back-pressure");

endmodule

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  id_pkg::word_t ds_inst,
    dec_if.dec            dec
);
    import id_pkg::*;

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    reg_addr_t   rd, rj, rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic        op_3r, op_shifti;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic        inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
    logic        cond_br;
    logic        need_ui5, need_si12, need_ui12, need_si20, need_si26, src2_is_4;

    assign op6 = ds_inst[31:26];
    assign op4 = ds_inst[25:22];
    assign op2 = ds_inst[21:20];
    assign op5 = ds_inst[19:15];
    assign rd  = ds_inst[4:0];
    assign rj  = ds_inst[9:5];
    assign rk  = ds_inst[14:10];
    assign i12 = ds_inst[21:10];
    assign i16 = ds_inst[25:10];
    assign i20 = ds_inst[24:5];
    // offs[25:16] sits in the low bits of the word
    assign i26 = {ds_inst[9:0], ds_inst[25:10]};

    assign op_3r     = op6 == OP6_SPECIAL && op4 == OP4_3R && op2 == OP2_3R;
    assign op_shifti = op6 == OP6_SPECIAL && op4 == OP4_SHIFTI && op2 == OP2_SHIFTI;

    assign inst_add_w     = op_3r && op5 == OP5_ADD;
    assign inst_sub_w     = op_3r && op5 == OP5_SUB;
    assign inst_slt       = op_3r && op5 == OP5_SLT;
    assign inst_sltu      = op_3r && op5 == OP5_SLTU;
    assign inst_nor       = op_3r && op5 == OP5_NOR;
    assign inst_and       = op_3r && op5 == OP5_AND;
    assign inst_or        = op_3r && op5 == OP5_OR;
    assign inst_xor       = op_3r && op5 == OP5_XOR;
    assign inst_slli_w    = op_shifti && op5 == OP5_SLLI;
    assign inst_srli_w    = op_shifti && op5 == OP5_SRLI;
    assign inst_srai_w    = op_shifti && op5 == OP5_SRAI;
    assign inst_slti      = op6 == OP6_SPECIAL && op4 == OP4_SLTI;
    assign inst_sltui     = op6 == OP6_SPECIAL && op4 == OP4_SLTUI;
    assign inst_addi_w    = op6 == OP6_SPECIAL && op4 == OP4_ADDI;
    assign inst_andi      = op6 == OP6_SPECIAL && op4 == OP4_ANDI;
    assign inst_ori       = op6 == OP6_SPECIAL && op4 == OP4_ORI;
    assign inst_xori      = op6 == OP6_SPECIAL && op4 == OP4_XORI;
    assign inst_lu12i_w   = op6 == OP6_LU12I && !ds_inst[25];
    assign inst_pcaddu12i = op6 == OP6_PCADDU12I && !ds_inst[25];
    assign inst_ld_w      = op6 == OP6_MEM && op4 == OP4_LD_W;
    assign inst_st_w      = op6 == OP6_MEM && op4 == OP4_ST_W;

    assign dec.is_jirl = op6 == OP6_JIRL;
    assign dec.is_b    = op6 == OP6_B;
    assign dec.is_bl   = op6 == OP6_BL;
    assign dec.is_beq  = op6 == OP6_BEQ;
    assign dec.is_bne  = op6 == OP6_BNE;
    assign dec.is_blt  = op6 == OP6_BLT;
    assign dec.is_bge  = op6 == OP6_BGE;
    assign dec.is_bltu = op6 == OP6_BLTU;
    assign dec.is_bgeu = op6 == OP6_BGEU;
    assign cond_br = dec.is_beq | dec.is_bne | dec.is_blt | dec.is_bge | dec.is_bltu
                   | dec.is_bgeu;

    // address and link computations go through the adder
    assign dec.alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                | dec.is_jirl | dec.is_bl | inst_pcaddu12i;
    assign dec.alu_op[ALU_SUB]  = inst_sub_w;
    assign dec.alu_op[ALU_SLT]  = inst_slt | inst_slti;
    assign dec.alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
    assign dec.alu_op[ALU_AND]  = inst_and | inst_andi;
    assign dec.alu_op[ALU_NOR]  = inst_nor;
    assign dec.alu_op[ALU_OR]   = inst_or | inst_ori;
    assign dec.alu_op[ALU_XOR]  = inst_xor | inst_xori;
    assign dec.alu_op[ALU_SLL]  = inst_slli_w;
    assign dec.alu_op[ALU_SRL]  = inst_srli_w;
    assign dec.alu_op[ALU_SRA]  = inst_srai_w;
    assign dec.alu_op[ALU_LUI]  = inst_lu12i_w;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign need_si26 = dec.is_b | dec.is_bl;
    assign src2_is_4 = dec.is_jirl | dec.is_bl;

    assign dec.imm = src2_is_4 ? 32'd4                      :
                     need_si20 ? {i20, 12'b0}               :
                     need_si12 ? {{20{i12[11]}}, i12}       :
                     need_ui12 ? {20'b0, i12}               :
                     need_ui5  ? {27'b0, rk}                :
                                 32'b0;

    // jirl shares the si16 form with the conditional branches
    assign dec.br_offs = need_si26 ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};

    assign dec.src1_is_pc  = dec.is_jirl | dec.is_bl | inst_pcaddu12i;
    assign dec.src2_is_imm = need_ui5 | need_si12 | need_ui12 | need_si20 | src2_is_4;

    assign dec.res_from_mem = inst_ld_w;
    assign dec.mem_we       = inst_st_w;
    // branches other than jirl and bl have no alu op
    assign dec.rf_we        = (|dec.alu_op) & !inst_st_w;
    assign dec.rf_waddr     = dec.is_bl ? REG_RA : rd;

    assign dec.raddr1  = rj;
    assign dec.raddr2  = (inst_st_w | cond_br) ? rd : rk;
    assign dec.need_r1 = ((|dec.alu_op) & !dec.src1_is_pc & !inst_lu12i_w)
                       | dec.is_jirl | cond_br;
    assign dec.need_r2 = ((|dec.alu_op) & !dec.src2_is_imm) | inst_st_w | cond_br;

    always_comb begin
        a_alu_op_onehot: assert final ($onehot0(dec.alu_op))
            else $error("alu_op %b is not one-hot for inst %h", dec.alu_op, ds_inst);
    end

endmodule

// ==== verilog/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass (
    input  id_pkg::word_t rdata1,
    input  id_pkg::word_t rdata2,
    input  logic          ds_valid,
    dec_if.bypass         dec,
    wb_fwd_if.bypass      fwd,
    output id_pkg::word_t rj_value,
    output id_pkg::word_t rkd_value,
    output logic          stall
);
    import id_pkg::*;

    logic es_hit1, ms_hit1, ws_hit1;
    logic es_hit2, ms_hit2, ws_hit2;

    // r0 never matches, so it keeps reading zero
    function automatic logic hit(input logic we, input reg_addr_t waddr, input reg_addr_t raddr);
        return we && waddr == raddr && raddr != '0;
    endfunction

    assign es_hit1 = hit(fwd.es_we, fwd.es_waddr, dec.raddr1);
    assign ms_hit1 = hit(fwd.ms_we, fwd.ms_waddr, dec.raddr1);
    assign ws_hit1 = hit(fwd.ws_we, fwd.ws_waddr, dec.raddr1);
    assign es_hit2 = hit(fwd.es_we, fwd.es_waddr, dec.raddr2);
    assign ms_hit2 = hit(fwd.ms_we, fwd.ms_waddr, dec.raddr2);
    assign ws_hit2 = hit(fwd.ws_we, fwd.ws_waddr, dec.raddr2);

    // youngest result wins
    assign rj_value  = es_hit1 ? fwd.es_wdata :
                       ms_hit1 ? fwd.ms_wdata :
                       ws_hit1 ? fwd.ws_wdata :
                                 rdata1;
    assign rkd_value = es_hit2 ? fwd.es_wdata :
                       ms_hit2 ? fwd.ms_wdata :
                       ws_hit2 ? fwd.ws_wdata :
                                 rdata2;

    // load data only exists after memory
    assign stall = ds_valid && fwd.es_res_from_mem
                && ((es_hit1 && dec.need_r1) || (es_hit2 && dec.need_r2));

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2,
    wb_fwd_if.rf_write        wb
);
    import id_pkg::*;

    word_t regs [32];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wb.ws_we && wb.ws_waddr != '0) begin
            regs[wb.ws_waddr] <= wb.ws_wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule
